// ==== src/panel_params_pkg.sv ====
// panel geometry constants
// framebuffer address and data widths derived from them

package panel_params_pkg;

    // panel size, each half scanned in parallel
    localparam int unsigned PIXEL_WIDTH      = 64;
    localparam int unsigned PIXEL_HALFHEIGHT = 16;
    localparam int unsigned BYTES_PER_PIXEL  = 1;

    // framebuffer word address is {row, column}
    localparam int unsigned COL_BITS      = $clog2(PIXEL_WIDTH);
    localparam int unsigned ROW_BITS      = $clog2(PIXEL_HALFHEIGHT);
    localparam int unsigned RAM_ADDR_BITS = COL_BITS + ROW_BITS;

    // RGB332 pixels, bottom half in the upper byte of a word
    localparam int unsigned PIXEL_BITS    = 8 * BYTES_PER_PIXEL;
    localparam int unsigned RAM_DATA_BITS = 2 * PIXEL_BITS;

    // load value of the fetch sequencer
    localparam int unsigned FETCH_CYCLES = 3;

endpackage

// ==== src/panel_types_pkg.sv ====
// scan FSM states, AXI response codes and the host register map

package panel_types_pkg;

    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        SHIFT,
        LATCH,
        DISPLAY
    } scan_state_t;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axi_resp_t;

    localparam int unsigned AXI_ADDR_BITS = 14;
    localparam int unsigned AXI_DATA_BITS = 32;

    // bit 13 clear selects framebuffer space, word n at byte 4n
    localparam int unsigned SPACE_BIT = 13;
    localparam logic [AXI_ADDR_BITS-1:0] FB_BASE   = 14'h0000;
    localparam logic [AXI_ADDR_BITS-1:0] CTRL_ADDR = 14'h2000;
    localparam int unsigned CTRL_ENABLE_BIT = 0;

endpackage

// ==== src/timeout.sv ====
// loadable down-counter
// running stays high while the count is nonzero

`timescale 1ns/1ps

module timeout #(
    parameter int unsigned COUNTER_WIDTH = 2,
    parameter int unsigned COUNT         = 3
) (
    input  logic                     reset,
    input  logic                     clk_in,
    input  logic                     start,
    output logic [COUNTER_WIDTH-1:0] counter,
    output logic                     running
);

    assign running = (counter != '0);

    always_ff @(posedge clk_in) begin
        if (reset) begin
            counter <= '0;
        end else if (start) begin
            counter <= COUNTER_WIDTH'(COUNT);
        end else if (running) begin
            counter <= counter - 1'b1;
        end
    end

endmodule

// ==== src/framebuffer_ram.sv ====
// dual-port framebuffer RAM
// host port writes and reads, scan port reads behind a clock enable

`timescale 1ns/1ps

module framebuffer_ram #(
    parameter int unsigned ADDR_BITS = panel_params_pkg::RAM_ADDR_BITS
) (
    input  logic                                     clk_in,
    input  logic                                     fb_we,
    input  logic [ADDR_BITS-1:0]                     fb_addr,
    input  logic [panel_params_pkg::RAM_DATA_BITS-1:0] fb_wdata,
    output logic [panel_params_pkg::RAM_DATA_BITS-1:0] fb_rdata,
    input  logic [ADDR_BITS-1:0]                     ram_address,
    input  logic                                     ram_clk_enable,
    output logic [panel_params_pkg::RAM_DATA_BITS-1:0] ram_data
);
    import panel_params_pkg::*;

    logic [RAM_DATA_BITS-1:0] mem [2**ADDR_BITS];

    // host port, read returns the old word on a write cycle
    always_ff @(posedge clk_in) begin
        if (fb_we) begin
            mem[fb_addr] <= fb_wdata;
        end
        fb_rdata <= mem[fb_addr];
    end

    // scan port holds its word between fetches
    always_ff @(posedge clk_in) begin
        if (ram_clk_enable) begin
            ram_data <= mem[ram_address];
        end
    end

endmodule

// ==== src/framebuffer_fetch.sv ====
// pixel fetch for one column of a row pair
// reads one framebuffer word and splits it into top and bottom pixels

`timescale 1ns/1ps

module framebuffer_fetch #(
    parameter int unsigned PIXEL_WIDTH      = panel_params_pkg::PIXEL_WIDTH,
    parameter int unsigned PIXEL_HALFHEIGHT = panel_params_pkg::PIXEL_HALFHEIGHT
) (
    input  logic                                           reset,
    input  logic                                           clk_in,
    input  logic [$clog2(PIXEL_WIDTH)-1:0]                 column_address,
    input  logic [$clog2(PIXEL_HALFHEIGHT)-1:0]            row_address,
    input  logic                                           pixel_load_start,
    input  logic [panel_params_pkg::RAM_DATA_BITS-1:0]     ram_data,
    output logic [$clog2(PIXEL_WIDTH)+$clog2(PIXEL_HALFHEIGHT)-1:0] ram_address,
    output logic                                           ram_clk_enable,
    output logic                                           fetch_busy,
    output logic [panel_params_pkg::PIXEL_BITS-1:0]        pixeldata_top,
    output logic [panel_params_pkg::PIXEL_BITS-1:0]        pixeldata_bottom
);
    import panel_params_pkg::*;

    localparam int unsigned FETCH_BITS = $clog2(FETCH_CYCLES + 1);
    // RAM word is valid one edge after the load
    localparam logic [FETCH_BITS-1:0] CAPTURE_COUNT = FETCH_BITS'(FETCH_CYCLES - 1);

    logic [FETCH_BITS-1:0] fetch_count;
    logic                  fetch_running;

    // row selects the block of PIXEL_WIDTH words
    assign ram_address    = {row_address, column_address};
    assign ram_clk_enable = fetch_running;
    assign fetch_busy     = fetch_running;

    timeout #(
        .COUNTER_WIDTH(FETCH_BITS),
        .COUNT        (FETCH_CYCLES)
    ) u_fetch_timer (
        .reset  (reset),
        .clk_in (clk_in),
        .start  (pixel_load_start),
        .counter(fetch_count),
        .running(fetch_running)
    );

    always_ff @(posedge clk_in) begin
        if (reset) begin
            pixeldata_top    <= '0;
            pixeldata_bottom <= '0;
        end else if (fetch_count == CAPTURE_COUNT) begin
            {pixeldata_bottom, pixeldata_top} <= ram_data;
        end
    end

endmodule

// ==== src/axil_fb_port.sv ====
// AXI4-Lite slave for the framebuffer host port and the control register
// one transaction in flight, reads return two cycles after the ar handshake

`timescale 1ns/1ps

module axil_fb_port #(
    parameter int unsigned ADDR_BITS = panel_params_pkg::RAM_ADDR_BITS
) (
    input  logic                                       reset,
    input  logic                                       clk_in,
    input  logic [panel_types_pkg::AXI_ADDR_BITS-1:0]  awaddr,
    input  logic                                       awvalid,
    output logic                                       awready,
    input  logic [panel_types_pkg::AXI_DATA_BITS-1:0]  wdata,
    input  logic                                       wvalid,
    output logic                                       wready,
    output panel_types_pkg::axi_resp_t                 bresp,
    output logic                                       bvalid,
    input  logic                                       bready,
    input  logic [panel_types_pkg::AXI_ADDR_BITS-1:0]  araddr,
    input  logic                                       arvalid,
    output logic                                       arready,
    output logic [panel_types_pkg::AXI_DATA_BITS-1:0]  rdata,
    output panel_types_pkg::axi_resp_t                 rresp,
    output logic                                       rvalid,
    input  logic                                       rready,
    output logic                                       fb_we,
    output logic [ADDR_BITS-1:0]                       fb_addr,
    output logic [panel_params_pkg::RAM_DATA_BITS-1:0] fb_wdata,
    input  logic [panel_params_pkg::RAM_DATA_BITS-1:0] fb_rdata,
    output logic                                       enable
);
    import panel_params_pkg::*;
    import panel_types_pkg::*;

    logic       busy;
    logic       write_hs;
    logic       read_hs;
    logic [1:0] read_pipe;
    logic       read_fb;
    logic       read_ctrl;

    function automatic logic is_fb(input logic [AXI_ADDR_BITS-1:0] addr);
        return !addr[SPACE_BIT];
    endfunction

    function automatic logic [ADDR_BITS-1:0] word_of(input logic [AXI_ADDR_BITS-1:0] addr);
        logic [AXI_ADDR_BITS-1:0] offset;
        offset = addr - FB_BASE;
        return offset[ADDR_BITS+1:2];
    endfunction

    assign write_hs = awready && awvalid && wready && wvalid;
    assign read_hs  = arready && arvalid;
    // a pending response stalls new requests
    assign busy = awready || arready || bvalid || rvalid || (read_pipe != 2'b00);

    always_ff @(posedge clk_in) begin
        if (reset) begin
            awready   <= 1'b0;
            wready    <= 1'b0;
            arready   <= 1'b0;
            bvalid    <= 1'b0;
            bresp     <= OKAY;
            rvalid    <= 1'b0;
            rresp     <= OKAY;
            read_pipe <= 2'b00;
            fb_we     <= 1'b0;
            enable    <= 1'b0;
        end else begin
            awready   <= 1'b0;
            wready    <= 1'b0;
            arready   <= 1'b0;
            fb_we     <= 1'b0;
            read_pipe <= {read_pipe[0], read_hs};
            // writes win when both arrive together
            if (!busy && awvalid && wvalid) begin
                awready <= 1'b1;
                wready  <= 1'b1;
            end else if (!busy && arvalid) begin
                arready <= 1'b1;
            end
            if (write_hs) begin
                fb_we  <= is_fb(awaddr);
                bvalid <= 1'b1;
                bresp  <= (is_fb(awaddr) || awaddr == CTRL_ADDR) ? OKAY : SLVERR;
                if (awaddr == CTRL_ADDR) begin
                    enable <= wdata[CTRL_ENABLE_BIT];
                end
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
            if (read_pipe[1]) begin
                rvalid <= 1'b1;
                rresp  <= (read_fb || read_ctrl) ? OKAY : SLVERR;
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // request payload and read data
    always_ff @(posedge clk_in) begin
        if (write_hs) begin
            fb_addr  <= word_of(awaddr);
            fb_wdata <= wdata[RAM_DATA_BITS-1:0];
        end else if (read_hs) begin
            fb_addr   <= word_of(araddr);
            read_fb   <= is_fb(araddr);
            read_ctrl <= (araddr == CTRL_ADDR);
        end
        if (read_pipe[1]) begin
            if (read_fb) begin
                rdata <= AXI_DATA_BITS'(fb_rdata);
            end else if (read_ctrl) begin
                rdata <= AXI_DATA_BITS'(enable);
            end else begin
                rdata <= '0;
            end
        end
    end

endmodule

// ==== src/scan_fsm.sv ====
// panel scan FSM
// per row: fetch and shift every column, latch, then display for a fixed time

`timescale 1ns/1ps

module scan_fsm #(
    parameter int unsigned PIXEL_WIDTH      = panel_params_pkg::PIXEL_WIDTH,
    parameter int unsigned PIXEL_HALFHEIGHT = panel_params_pkg::PIXEL_HALFHEIGHT,
    parameter int unsigned DISPLAY_CYCLES   = 256
) (
    input  logic                                reset,
    input  logic                                clk_in,
    input  logic                                enable,
    input  logic                                fetch_busy,
    output logic                                pixel_load_start,
    output logic [$clog2(PIXEL_WIDTH)-1:0]      column_address,
    output logic [$clog2(PIXEL_HALFHEIGHT)-1:0] row_address,
    output logic                                panel_clk,
    output logic                                panel_latch,
    output logic                                panel_oe,
    output logic [$clog2(PIXEL_HALFHEIGHT)-1:0] panel_row
);
    import panel_types_pkg::*;

    localparam int unsigned COL_BITS   = $clog2(PIXEL_WIDTH);
    localparam int unsigned ROW_BITS   = $clog2(PIXEL_HALFHEIGHT);
    localparam int unsigned TIMER_BITS = $clog2(DISPLAY_CYCLES + 1);
    localparam logic [COL_BITS-1:0] LAST_COL = COL_BITS'(PIXEL_WIDTH - 1);
    localparam logic [ROW_BITS-1:0] LAST_ROW = ROW_BITS'(PIXEL_HALFHEIGHT - 1);

    scan_state_t           state;
    logic                  fetch_started;
    logic [TIMER_BITS-1:0] display_count;

    // single start per column, masked once the fetch is under way
    assign pixel_load_start = (state == FETCH) && !fetch_started;
    assign panel_clk        = (state == SHIFT);
    assign panel_latch      = (state == LATCH);

    // output enable follows the display timer
    timeout #(
        .COUNTER_WIDTH(TIMER_BITS),
        .COUNT        (DISPLAY_CYCLES)
    ) u_display_timer (
        .reset  (reset),
        .clk_in (clk_in),
        .start  (panel_latch),
        .counter(display_count),
        .running(panel_oe)
    );

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state          <= IDLE;
            fetch_started  <= 1'b0;
            column_address <= '0;
            row_address    <= '0;
            panel_row      <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (enable) begin
                        column_address <= '0;
                        state          <= FETCH;
                    end
                end
                FETCH: begin
                    if (!fetch_started) begin
                        fetch_started <= 1'b1;
                    end else if (!fetch_busy) begin
                        fetch_started <= 1'b0;
                        state         <= SHIFT;
                    end
                end
                SHIFT: begin
                    if (column_address == LAST_COL) begin
                        // new row shows up while oe is low
                        panel_row <= row_address;
                        state     <= LATCH;
                    end else begin
                        column_address <= column_address + 1'b1;
                        state          <= FETCH;
                    end
                end
                LATCH: state <= DISPLAY;
                DISPLAY: begin
                    if (display_count == TIMER_BITS'(1)) begin
                        column_address <= '0;
                        row_address    <= (row_address == LAST_ROW) ? '0 : row_address + 1'b1;
                        state          <= enable ? FETCH : IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// ==== src/matrix_top.sv ====
// HUB75 matrix driver top level
// AXI4-Lite host port, framebuffer RAM, pixel fetch and scan FSM

`timescale 1ns/1ps

module matrix_top #(
    parameter int unsigned PIXEL_WIDTH      = panel_params_pkg::PIXEL_WIDTH,
    parameter int unsigned PIXEL_HALFHEIGHT = panel_params_pkg::PIXEL_HALFHEIGHT,
    parameter int unsigned DISPLAY_CYCLES   = 256
) (
    input  logic                                      reset,
    input  logic                                      clk_in,
    input  logic [panel_types_pkg::AXI_ADDR_BITS-1:0] awaddr,
    input  logic                                      awvalid,
    output logic                                      awready,
    input  logic [panel_types_pkg::AXI_DATA_BITS-1:0] wdata,
    input  logic                                      wvalid,
    output logic                                      wready,
    output panel_types_pkg::axi_resp_t                bresp,
    output logic                                      bvalid,
    input  logic                                      bready,
    input  logic [panel_types_pkg::AXI_ADDR_BITS-1:0] araddr,
    input  logic                                      arvalid,
    output logic                                      arready,
    output logic [panel_types_pkg::AXI_DATA_BITS-1:0] rdata,
    output panel_types_pkg::axi_resp_t                rresp,
    output logic                                      rvalid,
    input  logic                                      rready,
    output logic [panel_params_pkg::PIXEL_BITS-1:0]   panel_rgb_top,
    output logic [panel_params_pkg::PIXEL_BITS-1:0]   panel_rgb_bottom,
    output logic                                      panel_clk,
    output logic                                      panel_latch,
    output logic                                      panel_oe,
    output logic [$clog2(PIXEL_HALFHEIGHT)-1:0]       panel_row
);
    import panel_params_pkg::*;

    localparam int unsigned COL_BITS  = $clog2(PIXEL_WIDTH);
    localparam int unsigned ROW_BITS  = $clog2(PIXEL_HALFHEIGHT);
    localparam int unsigned ADDR_BITS = COL_BITS + ROW_BITS;

    // host port
    logic                     fb_we;
    logic [ADDR_BITS-1:0]     fb_addr;
    logic [RAM_DATA_BITS-1:0] fb_wdata;
    logic [RAM_DATA_BITS-1:0] fb_rdata;
    logic                     enable;

    // scan port and fetch control
    logic [ADDR_BITS-1:0]     ram_address;
    logic                     ram_clk_enable;
    logic [RAM_DATA_BITS-1:0] ram_data;
    logic [COL_BITS-1:0]      column_address;
    logic [ROW_BITS-1:0]      row_address;
    logic                     pixel_load_start;
    logic                     fetch_busy;

    axil_fb_port #(.ADDR_BITS(ADDR_BITS)) u_axil_fb_port (
        .reset, .clk_in,
        .awaddr, .awvalid, .awready, .wdata, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
        .fb_we, .fb_addr, .fb_wdata, .fb_rdata, .enable
    );

    framebuffer_ram #(.ADDR_BITS(ADDR_BITS)) u_framebuffer_ram (
        .clk_in, .fb_we, .fb_addr, .fb_wdata, .fb_rdata,
        .ram_address, .ram_clk_enable, .ram_data
    );

    framebuffer_fetch #(
        .PIXEL_WIDTH     (PIXEL_WIDTH),
        .PIXEL_HALFHEIGHT(PIXEL_HALFHEIGHT)
    ) u_framebuffer_fetch (
        .reset, .clk_in, .column_address, .row_address, .pixel_load_start,
        .ram_data, .ram_address, .ram_clk_enable, .fetch_busy,
        .pixeldata_top   (panel_rgb_top),
        .pixeldata_bottom(panel_rgb_bottom)
    );

    scan_fsm #(
        .PIXEL_WIDTH     (PIXEL_WIDTH),
        .PIXEL_HALFHEIGHT(PIXEL_HALFHEIGHT),
        .DISPLAY_CYCLES  (DISPLAY_CYCLES)
    ) u_scan_fsm (
        .reset, .clk_in, .enable, .fetch_busy, .pixel_load_start,
        .column_address, .row_address,
        .panel_clk, .panel_latch, .panel_oe, .panel_row
    );

endmodule

// ==== tb/matrix_top_properties.sv ====
// panel control checks for the scan FSM
// bound into every scan_fsm instance

`timescale 1ns/1ps

module matrix_top_properties #(
    parameter int unsigned ROW_BITS = 4
) (
    input logic                clk_in,
    input logic                reset,
    input logic                panel_clk,
    input logic                panel_latch,
    input logic                panel_oe,
    input logic [ROW_BITS-1:0] panel_row
);

    // failure counts, one per assertion
    int unsigned clk_failures   = 0;
    int unsigned latch_failures = 0;
    int unsigned row_failures   = 0;
    int unsigned failures;

    assign failures = clk_failures + latch_failures + row_failures;

    // shift clock is a single-cycle pulse
    clk_single_pulse: assert property (@(posedge clk_in) disable iff (reset)
        panel_clk |=> !panel_clk)
        else begin
            clk_failures++;
            $error("panel_clk stayed high for more than one cycle");
        end

    latch_outside_display: assert property (@(posedge clk_in) disable iff (reset)
        !(panel_latch && panel_oe))
        else begin
            latch_failures++;
            $error("panel_latch and panel_oe high together");
        end

    // row select must not move while the LEDs are lit
    row_stable_while_lit: assert property (@(posedge clk_in) disable iff (reset)
        panel_oe |=> (!panel_oe || $stable(panel_row)))
        else begin
            row_failures++;
            $error("panel_row changed while panel_oe was high");
        end

endmodule

bind scan_fsm matrix_top_properties #(
    .ROW_BITS($clog2(PIXEL_HALFHEIGHT))
) u_properties (
    .clk_in     (clk_in),
    .reset      (reset),
    .panel_clk  (panel_clk),
    .panel_latch(panel_latch),
    .panel_oe   (panel_oe),
    .panel_row  (panel_row)
);

// ==== tb/matrix_top_tb.sv ====
// testbench for the HUB75 matrix driver
// loads the framebuffer over AXI4-Lite, then follows two frames of panel scan

`timescale 1ns/1ps

module matrix_top_tb;
    import panel_params_pkg::*;
    import panel_types_pkg::*;

    localparam int COLS         = 8;
    localparam int ROWS         = 4;
    localparam int DISPLAY_TIME = 5;
    localparam int WORDS        = COLS * ROWS;
    localparam int IDX_BITS     = $clog2(WORDS + 1);
    // a column is the fetch plus one shift cycle, a row adds latch and display
    localparam int ROW_CYCLES   = COLS * (FETCH_CYCLES + 3) + 1 + DISPLAY_TIME;
    localparam int TXN_CYCLES   = 8;
    localparam int CYCLE_LIMIT  = 2 * ((2 * WORDS + 8) * TXN_CYCLES + 4 * ROWS * ROW_CYCLES);

    logic                     clk_in;
    logic                     reset;
    logic [AXI_ADDR_BITS-1:0] awaddr;
    logic                     awvalid;
    logic                     awready;
    logic [AXI_DATA_BITS-1:0] wdata;
    logic                     wvalid;
    logic                     wready;
    axi_resp_t                bresp;
    logic                     bvalid;
    logic                     bready;
    logic [AXI_ADDR_BITS-1:0] araddr;
    logic                     arvalid;
    logic                     arready;
    logic [AXI_DATA_BITS-1:0] rdata;
    axi_resp_t                rresp;
    logic                     rvalid;
    logic                     rready;
    logic [PIXEL_BITS-1:0]    panel_rgb_top;
    logic [PIXEL_BITS-1:0]    panel_rgb_bottom;
    logic                     panel_clk;
    logic                     panel_latch;
    logic                     panel_oe;
    logic [$clog2(ROWS)-1:0]  panel_row;

    // framebuffer words, then the expected control readback
    logic [15:0] testdata [0:WORDS];
    int          error_count;
    int          test_count;
    int          failed_count;
    int          cycle_count;

    matrix_top #(
        .PIXEL_WIDTH     (COLS),
        .PIXEL_HALFHEIGHT(ROWS),
        .DISPLAY_CYCLES  (DISPLAY_TIME)
    ) u_dut (.*);

    initial begin
        clk_in = 1'b0;
        forever #50 clk_in = ~clk_in;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk_in);
            cycle_count++;
        end
        $display("timeout after %0d cycles, a bus handshake or the scan stalled", cycle_count);
        $display("ERRORS FOUND");
        $finish;
    end

    function automatic logic [15:0] stored_word(input int index);
        return testdata[IDX_BITS'(index)];
    endfunction

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s expected 0x%0h, got 0x%0h",
                     $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        test_count++;
        if (error_count == errors_before) begin
            $display("test %s: passed", name);
        end else begin
            failed_count++;
            $display("test %s: failed with %0d errors", name, error_count - errors_before);
        end
    endtask

    task automatic axi_write(input logic [AXI_ADDR_BITS-1:0] addr,
                             input logic [AXI_DATA_BITS-1:0] data, output axi_resp_t resp);
        @(posedge clk_in);
        awaddr  <= addr;
        wdata   <= data;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        do begin
            @(negedge clk_in);
        end while (!(awready && wready));
        // aw and w transfer on this edge
        @(posedge clk_in);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        do begin
            @(negedge clk_in);
        end while (!bvalid);
        resp = bresp;
    endtask

    task automatic axi_read(input logic [AXI_ADDR_BITS-1:0] addr,
                            output logic [AXI_DATA_BITS-1:0] data, output axi_resp_t resp);
        @(posedge clk_in);
        araddr  <= addr;
        arvalid <= 1'b1;
        do begin
            @(negedge clk_in);
        end while (!arready);
        @(posedge clk_in);
        arvalid <= 1'b0;
        do begin
            @(negedge clk_in);
        end while (!rvalid);
        data = rdata;
        resp = rresp;
    endtask

    // follows panel rows from the first shift pulse through the display time
    task automatic monitor_rows(input int rows);
        int          pulses;
        int          oe_cycles;
        int          row;
        logic [15:0] word;
        for (int n = 0; n < rows; n++) begin
            row    = n % ROWS;
            pulses = 0;
            do begin
                @(negedge clk_in);
                if (panel_clk && pulses < COLS) begin
                    // bottom pixel in the upper byte
                    word = stored_word(row * COLS + pulses);
                    compare_value("panel_rgb_top", 32'(word[7:0]), 32'(panel_rgb_top));
                    compare_value("panel_rgb_bottom", 32'(word[15:8]), 32'(panel_rgb_bottom));
                end
                if (panel_clk) begin
                    pulses++;
                end
            end while (!panel_latch);
            compare_value("panel_clk pulses per row", COLS, pulses);
            oe_cycles = 0;
            @(negedge clk_in);
            while (panel_oe) begin
                compare_value("panel_row", row, 32'(panel_row));
                oe_cycles++;
                @(negedge clk_in);
            end
            compare_value("panel_oe cycles", DISPLAY_TIME, oe_cycles);
        end
    endtask

    task automatic check_idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk_in);
            compare_value("panel_oe", 0, 32'(panel_oe));
            compare_value("panel_clk", 0, 32'(panel_clk));
            compare_value("panel_latch", 0, 32'(panel_latch));
        end
    endtask

    initial begin
        axi_resp_t                resp;
        logic [AXI_DATA_BITS-1:0] data;
        int                       errors_before;
        error_count  = 0;
        test_count   = 0;
        failed_count = 0;
        reset        = 1'b1;
        awaddr       = '0;
        awvalid      = 1'b0;
        wdata        = '0;
        wvalid       = 1'b0;
        bready       = 1'b1;
        araddr       = '0;
        arvalid      = 1'b0;
        rready       = 1'b1;
        $readmemh("tb/matrix_testdata.hex", testdata);
        repeat (2) @(posedge clk_in);
        reset <= 1'b0;

        errors_before = error_count;
        check_idle(10);
        report_test("idle after reset", errors_before);

        errors_before = error_count;
        for (int n = 0; n < WORDS; n++) begin
            axi_write(AXI_ADDR_BITS'(4 * n), 32'(stored_word(n)), resp);
            compare_value("bresp", 32'(OKAY), 32'(resp));
        end
        for (int n = 0; n < WORDS; n++) begin
            axi_read(AXI_ADDR_BITS'(4 * n), data, resp);
            compare_value("rresp", 32'(OKAY), 32'(resp));
            compare_value("rdata", 32'(stored_word(n)), data);
        end
        report_test("framebuffer write and read", errors_before);

        // bit 13 set, but not the control register
        errors_before = error_count;
        axi_write(14'h2004, 32'hdead_beef, resp);
        compare_value("bresp", 32'(SLVERR), 32'(resp));
        axi_read(14'h2004, data, resp);
        compare_value("rresp", 32'(SLVERR), 32'(resp));
        compare_value("rdata", 0, data);
        report_test("unmapped address", errors_before);

        errors_before = error_count;
        axi_write(CTRL_ADDR, 32'h1, resp);
        compare_value("bresp", 32'(OKAY), 32'(resp));
        monitor_rows(2 * ROWS);
        report_test("panel scan over two frames", errors_before);

        errors_before = error_count;
        axi_read(CTRL_ADDR, data, resp);
        compare_value("rresp", 32'(OKAY), 32'(resp));
        compare_value("rdata", 32'(stored_word(WORDS)), data);
        report_test("enable readback", errors_before);

        // the row in progress finishes before the scan stops
        errors_before = error_count;
        axi_write(CTRL_ADDR, 32'h0, resp);
        compare_value("bresp", 32'(OKAY), 32'(resp));
        do begin
            @(negedge clk_in);
        end while (!panel_latch);
        do begin
            @(negedge clk_in);
        end while (panel_oe);
        check_idle(ROW_CYCLES);
        report_test("idle after disable", errors_before);

        if (u_dut.u_scan_fsm.u_properties.failures != 0) begin
            $display("scan FSM assertions failed %0d times",
                     u_dut.u_scan_fsm.u_properties.failures);
            error_count += int'(u_dut.u_scan_fsm.u_properties.failures);
        end
        $display("summary: %0d tests, %0d failed, %0d errors",
                 test_count, failed_count, error_count);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== tb/matrix_testdata.hex ====
// framebuffer words 0 to 31 at word address row*8+column, bottom pixel upper byte
// the last entry is the control register readback expected after enable is set
// row 0
a05f
a15e
a25d
a35c
a45b
a55a
a659
a758
// row 1
a857
a956
aa55
ab54
ac53
ad52
ae51
af50
// row 2
b04f
b14e
b24d
b34c
b44b
b54a
b649
b748
// row 3
b847
b946
ba45
bb44
bc43
bd42
be41
bf40
// control register
0001

// ==== verilog.f ====
src/panel_params_pkg.sv
src/panel_types_pkg.sv
src/timeout.sv
src/framebuffer_ram.sv
src/framebuffer_fetch.sv
src/axil_fb_port.sv
src/scan_fsm.sv
src/matrix_top.sv
tb/matrix_top_properties.sv
tb/matrix_top_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the matrix driver testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f verilog.f --top-module matrix_top_tb; then
    echo "verilator build failed"
    exit 1
fi

# keep running past assertion failures so the testbench can report them
if ! output=$(./obj_dir/Vmatrix_top_tb +verilator+error+limit+100); then
    echo "$output"
    echo "simulation exited with an error status"
    exit 1
fi

echo "$output"
if echo "$output" | grep -qx "NO ERRORS"; then
    exit 0
fi
echo "simulation reported failures"
exit 1
